//--- rtl/board_if.sv
`timescale 1ns/1ns
`default_nettype none

interface board_if
	import ttt_pkg::*;
();

	board_t board;
	logic placed; // one cycle per accepted mark
	logic move_en;
	player_t turn;
	logic clear; // one cycle, empties the board at the next edge

	modport selector (
		output board,
		output placed,
		input move_en,
		input turn,
		input clear
	);

	// shared by both checkers
	modport chk (
		input board,
		input placed
	);

	modport referee (
		input placed,
		output move_en,
		output turn,
		output clear
	);

endinterface

`default_nettype wire

//--- rtl/cell_selector.sv
`timescale 1ns/1ns
`default_nettype none

module cell_selector
	import ttt_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input logic sel,
	board_if.selector bus,
	output pos_t cursor
);

	board_t board_q;
	logic placed_q;
	logic can_down;
	logic can_up;
	logic can_left;
	logic can_right;
	logic can_place;

	assign can_down = cursor <= 4'd6;
	assign can_up = cursor >= 4'd4;
	assign can_left = (cursor != 4'd1) && (cursor != 4'd4) && (cursor != 4'd7); // no row wrap
	assign can_right = (cursor != 4'd3) && (cursor != 4'd6) && (cursor != 4'd9);

	// a select during the placed cycle would still see the old turn
	assign can_place = bus.move_en && !placed_q && (board_q[cursor] == CELL_EMPTY);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cursor <= POS_CENTRE;
			board_q <= {9{CELL_EMPTY}};
			placed_q <= 1'b0;
		end
		else
		begin
			placed_q <= 1'b0;
			if (bus.clear)
			begin
				board_q <= {9{CELL_EMPTY}};
				cursor <= POS_CENTRE;
			end
			else if (down && can_down)
				cursor <= cursor + 4'd3;
			else if (up && can_up)
				cursor <= cursor - 4'd3;
			else if (left && can_left)
				cursor <= cursor - 4'd1;
			else if (right && can_right)
				cursor <= cursor + 4'd1;
			else if (sel && can_place)
			begin
				board_q[cursor] <= player_mark(bus.turn);
				placed_q <= 1'b1;
				cursor <= POS_CENTRE; // back to centre for the next player
			end
		end
	end

	assign bus.board = board_q;
	assign bus.placed = placed_q;

	a_cursor_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		(cursor >= 4'd1) && (cursor <= 4'd9));

	// a mark, once written, only goes away through new_game
	for (genvar i = 1; i <= 9; i++)
	begin : g_keep
		a_cell_kept: assert property (@(posedge clk) disable iff (!rst_n)
			(board_q[i] != CELL_EMPTY) && !bus.clear |=> board_q[i] == $past(board_q[i]));
	end

endmodule

`default_nettype wire

//--- rtl/draw_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module draw_predictor
	import ttt_pkg::*;
(
	input logic clk,
	input logic rst_n,
	board_if.chk bus,
	output logic blocked
);

	logic [NUM_LINES-1:0] dead;
	logic full;

	function automatic logic line_has(board_t b, int l, cell_t m);
		return (b[LINES[l][0]] == m) || (b[LINES[l][1]] == m) || (b[LINES[l][2]] == m);
	endfunction

	// a line holding both marks can never be won
	always_comb
	begin
		for (int l = 0; l < NUM_LINES; l++)
			dead[l] = line_has(bus.board, l, CELL_P1) && line_has(bus.board, l, CELL_P2);
	end

	always_comb
	begin
		full = 1'b1;
		for (int p = 1; p <= 9; p++)
		begin
			if (bus.board[p] == CELL_EMPTY)
				full = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			blocked <= 1'b0;
		else if (bus.placed)
			blocked <= (&dead) || full;
	end

endmodule

`default_nettype wire

//--- rtl/game_referee.sv
`timescale 1ns/1ns
`default_nettype none

module game_referee
	import ttt_pkg::*;
#(
	parameter int SCORE_W = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic new_game,
	input logic win,
	input player_t win_player,
	input logic blocked,
	board_if.referee bus,
	output logic game_over,
	output winner_t winner,
	output logic [SCORE_W-1:0] p1_score,
	output logic [SCORE_W-1:0] p2_score,
	output logic [SCORE_W-1:0] draw_count
);

	ref_state_t state;
	player_t turn_q;
	logic move_en_q;
	logic clear_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			clear_q <= 1'b0;
		else
			clear_q <= new_game;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= PLAY;
			turn_q <= P1;
			move_en_q <= 1'b1;
			winner <= NONE;
			p1_score <= '0;
			p2_score <= '0;
			draw_count <= '0;
		end
		else if (clear_q)
		begin
			state <= PLAY; // scores survive a new game
			turn_q <= P1;
			move_en_q <= 1'b1;
			winner <= NONE;
		end
		else
		begin
			case (state)
				PLAY:
				begin
					if (bus.placed)
					begin
						state <= EVAL;
						move_en_q <= 1'b0;
					end
				end
				EVAL:
				begin
					if (win)
					begin
						state <= OVER;
						if (win_player == P1)
						begin
							winner <= P1_WIN;
							if (p1_score != '1)
								p1_score <= p1_score + 1'b1;
						end
						else
						begin
							winner <= P2_WIN;
							if (p2_score != '1)
								p2_score <= p2_score + 1'b1;
						end
					end
					else if (blocked)
					begin
						state <= OVER;
						winner <= DRAW;
						if (draw_count != '1)
							draw_count <= draw_count + 1'b1;
					end
					else
					begin
						state <= PLAY;
						turn_q <= (turn_q == P1) ? P2 : P1;
						move_en_q <= 1'b1;
					end
				end
				default: ; // OVER waits for new_game
			endcase
		end
	end

	assign game_over = (state == OVER);
	assign bus.turn = turn_q;
	assign bus.move_en = move_en_q;
	assign bus.clear = clear_q;

	a_hold_off: assert property (@(posedge clk) disable iff (!rst_n)
		(state != PLAY) |-> !bus.move_en);

endmodule

`default_nettype wire

//--- rtl/line_checker.sv
`timescale 1ns/1ns
`default_nettype none

module line_checker
	import ttt_pkg::*;
(
	input logic clk,
	input logic rst_n,
	board_if.chk bus,
	output logic win,
	output player_t win_player
);

	logic [NUM_LINES-1:0] p1_line;
	logic [NUM_LINES-1:0] p2_line;

	function automatic logic line_full_of(board_t b, int l, cell_t m);
		return (b[LINES[l][0]] == m) && (b[LINES[l][1]] == m) && (b[LINES[l][2]] == m);
	endfunction

	always_comb
	begin
		for (int l = 0; l < NUM_LINES; l++)
		begin
			p1_line[l] = line_full_of(bus.board, l, CELL_P1);
			p2_line[l] = line_full_of(bus.board, l, CELL_P2);
		end
	end

	// only a fresh mark can change the result
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			win <= 1'b0;
			win_player <= P1;
		end
		else if (bus.placed)
		begin
			win <= (|p1_line) || (|p2_line);
			if (|p2_line)
				win_player <= P2;
			else
				win_player <= P1;
		end
	end

	// play stops at the first line, so two owners means a missed win
	a_single_owner: assert property (@(posedge clk) disable iff (!rst_n)
		!((|p1_line) && (|p2_line)));

endmodule

`default_nettype wire

//--- rtl/ttt_pkg.sv
`default_nettype none

package ttt_pkg;

	typedef logic [1:0] cell_t;
	localparam cell_t CELL_EMPTY = 2'b00;
	localparam cell_t CELL_P1 = 2'b11;
	localparam cell_t CELL_P2 = 2'b01;

	typedef logic [3:0] pos_t; // 1..9 in rows, 5 is the centre
	localparam pos_t POS_CENTRE = 4'd5;

	typedef cell_t [9:1] board_t;

	typedef enum logic {P1 = 1'b0, P2 = 1'b1} player_t;
	typedef enum logic [1:0] {PLAY, EVAL, OVER} ref_state_t;
	typedef enum logic [1:0] {NONE, P1_WIN, P2_WIN, DRAW} winner_t;

	localparam int NUM_LINES = 8;

	// three rows, three columns, two diagonals
	localparam pos_t LINES [NUM_LINES][3] = '{
		'{4'd1, 4'd2, 4'd3},
		'{4'd4, 4'd5, 4'd6},
		'{4'd7, 4'd8, 4'd9},
		'{4'd1, 4'd4, 4'd7},
		'{4'd2, 4'd5, 4'd8},
		'{4'd3, 4'd6, 4'd9},
		'{4'd1, 4'd5, 4'd9},
		'{4'd3, 4'd5, 4'd7}
	};

	function automatic cell_t player_mark(player_t p);
		return (p == P1) ? CELL_P1 : CELL_P2;
	endfunction

endpackage

`default_nettype wire

//--- rtl/ttt_top.sv
`timescale 1ns/1ns
`default_nettype none

module ttt_top
	import ttt_pkg::*;
#(
	parameter int SCORE_W = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input logic sel,
	input logic new_game,
	output pos_t cursor,
	output board_t board,
	output player_t turn,
	output logic game_over,
	output winner_t winner,
	output logic [SCORE_W-1:0] p1_score,
	output logic [SCORE_W-1:0] p2_score,
	output logic [SCORE_W-1:0] draw_count
);

	logic win;
	player_t win_player;
	logic blocked;

	board_if bus_i ();

	cell_selector sel_i (
		.clk(clk),
		.rst_n(rst_n),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.sel(sel),
		.bus(bus_i),
		.cursor(cursor)
	);

	line_checker line_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus_i),
		.win(win),
		.win_player(win_player)
	);

	draw_predictor draw_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus_i),
		.blocked(blocked)
	);

	game_referee #(
		.SCORE_W(SCORE_W)
	) ref_i (
		.clk(clk),
		.rst_n(rst_n),
		.new_game(new_game),
		.win(win),
		.win_player(win_player),
		.blocked(blocked),
		.bus(bus_i),
		.game_over(game_over),
		.winner(winner),
		.p1_score(p1_score),
		.p2_score(p2_score),
		.draw_count(draw_count)
	);

	assign board = bus_i.board;
	assign turn = bus_i.turn;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tic-tac-toe testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ttt_tb -f vlog.f -o ttt_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ttt_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
exit 0

//--- tb/ttt_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ttt_tb
	import ttt_pkg::*;
;

	localparam int BTN_DOWN = 0;
	localparam int BTN_UP = 1;
	localparam int BTN_LEFT = 2;
	localparam int BTN_RIGHT = 3;
	localparam int BTN_SEL = 4;
	localparam int BTN_NEW = 5;
	localparam logic [1:0] MARK_P1 = 2'b11;
	localparam logic [1:0] MARK_P2 = 2'b01;
	localparam int NAV_PRESSES = 40;
	localparam int MAX_PLACES = 32;
	localparam int PLACE_CYCLES = 16; // worst case path plus select and settle

	logic clk;
	logic rst_n;
	logic up;
	logic down;
	logic left;
	logic right;
	logic sel;
	logic new_game;
	pos_t cursor;
	board_t board;
	player_t turn;
	logic game_over;
	winner_t winner;
	logic [3:0] p1_score;
	logic [3:0] p2_score;
	logic [3:0] draw_count;

	// reference model
	logic [1:0] exp_board [1:9];
	logic [3:0] exp_cursor;
	player_t exp_turn;
	winner_t exp_winner;
	int exp_p1;
	int exp_p2;
	int exp_draw;
	string test_name;
	integer seed = 86050;

	ttt_top #(.SCORE_W(4)) dut_i (
		.clk(clk), .rst_n(rst_n), .up(up), .down(down), .left(left), .right(right),
		.sel(sel), .new_game(new_game), .cursor(cursor), .board(board), .turn(turn),
		.game_over(game_over), .winner(winner), .p1_score(p1_score),
		.p2_score(p2_score), .draw_count(draw_count)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("Error: test %s, %s expected %0d, actual %0d", test_name, what,
				expected, actual);
			$display("Simulation failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_all();
		check_value("cursor", exp_cursor, cursor);
		for (int p = 1; p <= 9; p++)
			check_value($sformatf("cell %0d", p), exp_board[p], board[p]);
		check_value("turn", exp_turn, turn);
		check_value("winner", exp_winner, winner);
		check_value("game_over", (exp_winner != NONE), game_over);
		check_value("p1_score", exp_p1, p1_score);
		check_value("p2_score", exp_p2, p2_score);
		check_value("draw_count", exp_draw, draw_count);
	endtask

	// one-cycle button pulse, driven on the falling edge
	task automatic press(input int btn);
		@(negedge clk);
		down = (btn == BTN_DOWN);
		up = (btn == BTN_UP);
		left = (btn == BTN_LEFT);
		right = (btn == BTN_RIGHT);
		sel = (btn == BTN_SEL);
		new_game = (btn == BTN_NEW);
		@(negedge clk);
		{down, up, left, right, sel, new_game} = '0;
	endtask

	function automatic logic [3:0] moved(input logic [3:0] c, input int btn);
		int row;
		int col;
		row = (c - 1) / 3;
		col = (c - 1) % 3;
		case (btn)
			BTN_DOWN: if (row < 2) row++;
			BTN_UP: if (row > 0) row--;
			BTN_LEFT: if (col > 0) col--; // no wrap into the row above
			BTN_RIGHT: if (col < 2) col++;
			default: ;
		endcase
		return 4'(row * 3 + col + 1);
	endfunction

	task automatic move(input int btn);
		press(btn);
		exp_cursor = moved(exp_cursor, btn);
		check_value("cursor", exp_cursor, cursor);
	endtask

	task automatic goto_cell(input logic [3:0] target);
		while (exp_cursor != target)
		begin
			if ((exp_cursor - 1) / 3 < (target - 1) / 3)
				move(BTN_DOWN);
			else if ((exp_cursor - 1) / 3 > (target - 1) / 3)
				move(BTN_UP);
			else if (exp_cursor > target)
				move(BTN_LEFT);
			else
				move(BTN_RIGHT);
		end
	endtask

	// result is the outcome this mark should produce
	task automatic place(input logic [3:0] pos, input winner_t result);
		goto_cell(pos);
		press(BTN_SEL);
		repeat (3) @(negedge clk);
		exp_board[pos] = (exp_turn == P1) ? MARK_P1 : MARK_P2;
		exp_cursor = 4'd5;
		exp_winner = result;
		case (result)
			NONE: exp_turn = (exp_turn == P1) ? P2 : P1;
			P1_WIN: exp_p1++;
			P2_WIN: exp_p2++;
			default: exp_draw++;
		endcase
		check_all();
	endtask

	task automatic ignored_select();
		press(BTN_SEL);
		repeat (3) @(negedge clk);
		check_all();
	endtask

	task automatic start_new_game();
		press(BTN_NEW);
		@(negedge clk); // clear acts one edge after new_game
		for (int p = 1; p <= 9; p++)
			exp_board[p] = 2'b00;
		exp_cursor = 4'd5;
		exp_turn = P1;
		exp_winner = NONE;
		check_all();
	endtask

	task automatic test_reset();
		test_name = "reset";
		check_all();
	endtask

	task automatic test_navigation();
		test_name = "navigation";
		for (int i = 0; i < NAV_PRESSES; i++)
			move($unsigned($random(seed)) % 4);
	endtask

	task automatic test_p1_row_win();
		test_name = "p1_row_win";
		place(4'd1, NONE);
		place(4'd4, NONE);
		place(4'd2, NONE);
		place(4'd5, NONE);
		place(4'd3, P1_WIN);
		goto_cell(4'd6);
		ignored_select(); // game is over
	endtask

	task automatic test_ignored_select();
		test_name = "ignored_select";
		start_new_game();
		place(4'd5, NONE);
		ignored_select(); // centre is taken
		goto_cell(4'd9);
		start_new_game();
	endtask

	task automatic test_draws();
		test_name = "early_draw";
		place(4'd5, NONE);
		place(4'd1, NONE);
		place(4'd3, NONE);
		place(4'd7, NONE);
		place(4'd4, NONE);
		place(4'd6, NONE);
		place(4'd8, NONE);
		place(4'd2, DRAW); // every line dead, cell 9 still empty
		test_name = "full_draw";
		start_new_game();
		place(4'd1, NONE);
		place(4'd2, NONE);
		place(4'd3, NONE);
		place(4'd5, NONE);
		place(4'd4, NONE);
		place(4'd7, NONE);
		place(4'd6, NONE);
		place(4'd9, NONE);
		place(4'd8, DRAW);
	endtask

	task automatic test_p2_diag_win();
		test_name = "p2_diag_win";
		start_new_game();
		place(4'd2, NONE);
		place(4'd1, NONE);
		place(4'd3, NONE);
		place(4'd5, NONE);
		place(4'd4, NONE);
		place(4'd9, P2_WIN);
	endtask

	initial
	begin
		#((16 + 2 * NAV_PRESSES + MAX_PLACES * PLACE_CYCLES + 200) * 20);
		$display("Timeout: the tests did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		{down, up, left, right, sel, new_game} = '0;
		for (int p = 1; p <= 9; p++)
			exp_board[p] = 2'b00;
		exp_cursor = 4'd5;
		exp_turn = P1;
		exp_winner = NONE;
		exp_p1 = 0;
		exp_p2 = 0;
		exp_draw = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_navigation();
		test_p1_row_win();
		test_ignored_select();
		test_draws();
		test_p2_diag_win();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/ttt_pkg.sv
rtl/board_if.sv
rtl/cell_selector.sv
rtl/line_checker.sv
rtl/draw_predictor.sv
rtl/game_referee.sv
rtl/ttt_top.sv
tb/ttt_tb.sv
